//--- include/cpu_consts.svh
// Encodings for the single-cycle MIPS subset core
// Opcodes, R-type functs, ALU operations and the link register
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// I-type opcodes
`define BNE         6'd5
`define LW          6'd35
`define SW          6'd43
`define XORI        6'd14

// J-type opcodes
`define J           6'd2
`define JAL         6'd3

// R-type opcode, the funct field selects the operation
`define RTYPE       6'd0

// R-type functs
`define JR_F        6'd8
`define ADD_F       6'd32
`define SUB_F       6'd34
`define SLT_F       6'd42

// ALU operation codes
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_XOR     3'd2
`define ALU_SLT     3'd3

// JAL link register
`define RETURN_REG  5'd31

`endif

//--- rtl/cpuPkg.sv
// Shared types for the single-cycle core
// Control word layout and write-back selectors
package cpuPkg;

    // Destination register of a write-back
    typedef enum logic [1:0] {
        RT   = 2'd0,
        RD   = 2'd1,
        LINK = 2'd2  // Register 31, JAL only
    } wrAddrSel_t;

    // Source of the write-back value
    typedef enum logic [1:0] {
        MEM    = 2'd0,  // Load data
        ALU    = 2'd1,
        PCNEXT = 2'd2   // Return address for JAL
    } wrDataSel_t;

    // All-zero word is a no-op
    typedef struct packed {
        logic       regWrEn;
        logic       memWrEn;
        wrAddrSel_t wrAddrSel;
        logic       aluSrcReg;   // Set for register operand, clear for immediate
        logic [2:0] aluOp;
        logic       zeroExtImm;
        wrDataSel_t wrDataSel;
        logic       jumpReg;
        logic       jump;
        logic       branch;
    } ctrlWord_t;

endpackage

//--- rtl/controlDecoder.sv
// Control decoder
// Maps opcode and funct onto the packed control word
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlDecoder (
    input  logic [5:0]        opcode,
    input  logic [5:0]        funct,
    output cpuPkg::ctrlWord_t ctrl
);
    import cpuPkg::*;

    ctrlWord_t opCtrl;
    ctrlWord_t functCtrl;

    // Opcode table
    always_comb begin
        opCtrl = '0;
        case (opcode)
            `LW: begin
                opCtrl.regWrEn   = 1'b1;
                opCtrl.wrAddrSel = RT;
                opCtrl.aluOp     = `ALU_ADD;  // Base plus offset
                opCtrl.wrDataSel = MEM;
            end
            `SW: begin
                opCtrl.memWrEn = 1'b1;
                opCtrl.aluOp   = `ALU_ADD;
            end
            `BNE: begin
                opCtrl.aluSrcReg = 1'b1;
                opCtrl.aluOp     = `ALU_SUB;  // Nonzero difference means not equal
                opCtrl.branch    = 1'b1;
            end
            `XORI: begin
                opCtrl.regWrEn    = 1'b1;
                opCtrl.wrAddrSel  = RT;
                opCtrl.aluOp      = `ALU_XOR;
                opCtrl.zeroExtImm = 1'b1;
                opCtrl.wrDataSel  = ALU;
            end
            `J: begin
                opCtrl.jump = 1'b1;
            end
            `JAL: begin
                opCtrl.regWrEn   = 1'b1;
                opCtrl.wrAddrSel = LINK;
                opCtrl.wrDataSel = PCNEXT;
                opCtrl.jump      = 1'b1;
            end
            default: opCtrl = '0;
        endcase
    end

    // R-type funct table
    always_comb begin
        functCtrl = '0;
        case (funct)
            `JR_F: begin
                functCtrl.jumpReg = 1'b1;
                functCtrl.jump    = 1'b1;
            end
            `ADD_F, `SUB_F, `SLT_F: begin
                functCtrl.regWrEn   = 1'b1;
                functCtrl.wrAddrSel = RD;
                functCtrl.aluSrcReg = 1'b1;
                functCtrl.wrDataSel = ALU;
                if (funct == `ADD_F)
                    functCtrl.aluOp = `ALU_ADD;
                else if (funct == `SUB_F)
                    functCtrl.aluOp = `ALU_SUB;
                else
                    functCtrl.aluOp = `ALU_SLT;
            end
            default: functCtrl = '0;
        endcase
    end

    assign ctrl = (opcode == `RTYPE) ? functCtrl : opCtrl;

endmodule

//--- rtl/alu.sv
// ALU for the core
// Add, subtract, xor and signed set-less-than with a zero flag
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  op,
    output logic [31:0] result,
    output logic        zero
);

    logic [31:0] sum;
    logic [31:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            `ALU_ADD: result = sum;
            `ALU_SUB: result = diff;
            `ALU_XOR: result = a ^ b;
            `ALU_SLT: begin
                // Signed compare
                if ($signed(a) < $signed(b))
                    result = 32'd1;
                else
                    result = 32'd0;
            end
            default: result = 32'd0;
        endcase
    end

    assign zero = (result == 32'd0);  // Drives the BNE decision

endmodule

//--- rtl/regFile.sv
// Register file, 32 x 32 bits
// Two combinational reads, one clocked write, r0 hard zero
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    input  logic        wrEn,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;  // r0 writes dropped
        end
    end

    // Visible to the next instruction after the edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

//--- rtl/fetchUnit.sv
// Fetch unit
// Holds the PC and picks the next one from JR, jump, branch or sequential
`timescale 1ns/1ps

module fetchUnit (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::ctrlWord_t ctrl,
    input  logic              aluZero,
    input  logic [31:0]       branchOffset,
    input  logic [25:0]       jumpIndex,
    input  logic [31:0]       regTarget,
    output logic [31:0]       pc,
    output logic [31:0]       pcPlus4
);

    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic        takeBranch;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};

    // BNE: taken when the SUB result is nonzero
    assign takeBranch = ctrl.branch && !aluZero;

    always_comb begin
        if (ctrl.jumpReg)
            nextPc = regTarget;
        else if (ctrl.jump)
            nextPc = jumpTarget;
        else if (takeBranch)
            nextPc = branchTarget;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= 32'd0;
        else
            pc <= nextPc;
    end

    // Catches a misaligned JR target from the register file
    pcAligned: assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    ) else $error("PC left word alignment");

endmodule

//--- rtl/cpuCore.sv
// Single-cycle MIPS subset core
// Fetch, decode, register file, ALU and memory ports in one cycle
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuCore (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imemAddr,
    input  logic [31:0] instr,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWrData,
    output logic        dmemWe,
    input  logic [31:0] dmemRdData
);
    import cpuPkg::*;

    ctrlWord_t   ctrl;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] extImm;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        aluZero;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    fetchUnit fetch (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .aluZero      (aluZero),
        .branchOffset (extImm),
        .jumpIndex    (instr[25:0]),
        .regTarget    (rdDataA),  // JR through rs
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    controlDecoder decoder (
        .opcode (instr[31:26]),
        .funct  (instr[5:0]),
        .ctrl   (ctrl)
    );

    // XORI zero-extends, everything else sign-extends
    assign extImm = ctrl.zeroExtImm ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign aluB   = ctrl.aluSrcReg ? rdDataB : extImm;

    always_comb begin
        case (ctrl.wrAddrSel)
            RD:      wrAddr = instr[15:11];
            LINK:    wrAddr = `RETURN_REG;
            default: wrAddr = instr[20:16];
        endcase
    end

    always_comb begin
        case (ctrl.wrDataSel)
            MEM:     wrData = dmemRdData;
            PCNEXT:  wrData = pcPlus4;
            default: wrData = aluResult;
        endcase
    end

    regFile regs (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (instr[25:21]),
        .rdAddrB (instr[20:16]),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (ctrl.regWrEn),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    alu execAlu (
        .a      (rdDataA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign imemAddr   = pc;
    assign dmemAddr   = aluResult;
    assign dmemWrData = rdDataB;
    assign dmemWe     = ctrl.memWrEn && !rst;  // No store escapes during reset

    // Word-only data port, low address bits are dropped by the memory
    memAligned: assert property (
        @(posedge clk) disable iff (rst)
        (ctrl.memWrEn || (ctrl.regWrEn && ctrl.wrDataSel == MEM))
            |-> dmemAddr[1:0] == 2'b00
    ) else $error("Data access to a misaligned address");

endmodule

//--- bench/tbCpu.sv
// Testbench for the single-cycle core
// Models both memories, replays the data file and checks the store trace
`timescale 1ns/1ps

module tbCpu;

    localparam int memWords    = 256;
    localparam int dataWords   = 256;
    localparam int resetCycles = 16;
    localparam logic [31:0] resetStore = 32'hAC00_0000;  // sw r0, 0(r0)

    logic        clk;
    logic        rst;
    logic [31:0] imemAddr;
    logic [31:0] instr;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWrData;
    logic        dmemWe;
    logic [31:0] dmemRdData;

    logic [31:0] testData [dataWords];
    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    logic [31:0] dmemImage [memWords];

    int progLen;
    int preloadCount;
    int storeCount;
    int expBase;
    int storesSeen;
    int valueErrors;
    int otherErrors;
    int cycleCount;
    int cycleLimit;

    cpuCore DUT (
        .clk        (clk),
        .rst        (rst),
        .imemAddr   (imemAddr),
        .instr      (instr),
        .dmemAddr   (dmemAddr),
        .dmemWrData (dmemWrData),
        .dmemWe     (dmemWe),
        .dmemRdData (dmemRdData)
    );

    always #5 clk = ~clk;

    // Store word offered while rst is high
    assign instr      = rst ? resetStore : imem[imemAddr[9:2]];  // Word addressed, same-cycle read
    assign dmemRdData = dmem[dmemAddr[9:2]];

    // Preload image copied in while rst is high
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < memWords; i++) begin
                dmem[i[7:0]] <= dmemImage[i[7:0]];
            end
        end else if (dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWrData;
        end
    end

    function automatic logic [31:0] dataWord(input int idx);
        return testData[idx[7:0]];
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
            valueErrors++;
        end
    endtask

    // Next store in the trace, or an extra one
    task automatic handleStore();
        int idx;
        idx = expBase + 2 * storesSeen;
        if (storesSeen < storeCount) begin
            checkValue($sformatf("store %0d address", storesSeen), dmemAddr, dataWord(idx));
            checkValue($sformatf("store %0d data", storesSeen), dmemWrData, dataWord(idx + 1));
        end else begin
            $display("Unexpected extra store to address %h at time %0t", dmemAddr, $time);
            otherErrors++;
        end
        storesSeen++;
    endtask

    // Counts, then program, preload pairs and expected store pairs
    task automatic loadTestData();
        int preBase;
        logic [31:0] addr;
        for (int i = 0; i < dataWords; i++) begin
            testData[i[7:0]] = '0;
        end
        $readmemh("bench/cpu_testdata.txt", testData);
        progLen      = int'(testData[0]);
        preloadCount = int'(testData[1]);
        storeCount   = int'(testData[2]);
        preBase      = 3 + progLen;
        expBase      = preBase + 2 * preloadCount;
        if (progLen == 0 || storeCount == 0 || progLen > memWords ||
            expBase + 2 * storeCount > dataWords) begin
            $display("Test data file is missing, empty or holds bad counts");
            otherErrors++;
            progLen      = 0;
            preloadCount = 0;
            storeCount   = 0;
        end
        for (int i = 0; i < memWords; i++) begin
            imem[i[7:0]]      = 32'hFC00_0000 | i;         // Unlisted opcode, a no-op
            dmemImage[i[7:0]] = 32'hA500_0000 | (i << 2);  // Tagged with its byte address
        end
        for (int i = 0; i < progLen; i++) begin
            imem[i[7:0]] = dataWord(3 + i);
        end
        for (int i = 0; i < preloadCount; i++) begin
            addr = dataWord(preBase + 2 * i);
            dmemImage[addr[9:2]] = dataWord(preBase + 2 * i + 1);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        storesSeen  = 0;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount  = 0;
        loadTestData();
        cycleLimit = progLen * 4 + 200;

        // PC pinned at zero, no store while in reset
        repeat (resetCycles) begin
            @(negedge clk);
            checkValue("PC during reset", imemAddr, 32'd0);
            checkValue("store enable during reset", {31'd0, dmemWe}, 32'd0);
        end
        @(posedge clk);
        rst <= 1'b0;

        while (storesSeen < storeCount && cycleCount < cycleLimit) begin
            @(negedge clk);
            cycleCount++;
            if (cycleCount == 1)
                checkValue("first fetch address", imemAddr, 32'd0);
            if (dmemWe)
                handleStore();
        end

        if (storesSeen < storeCount) begin
            $display("Cycle limit of %0d reached, %0d of %0d expected stores never appeared",
                     cycleLimit, storeCount - storesSeen, storeCount);
            otherErrors += storeCount - storesSeen;
        end else begin
            // Program spins in its final loop, nothing more may be stored
            repeat (progLen) begin
                @(negedge clk);
                if (dmemWe)
                    handleStore();
            end
        end

        $display("Value mismatches: %0d, other failures: %0d, stores seen: %0d of %0d",
                 valueErrors, otherErrors, storesSeen, storeCount);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- bench/cpu_testdata.txt
// First line: program word count, preload pair count, expected store count
// Then program words, preload pairs (address value), expected stores (address value)
00000021 00000003 0000000C
// Program, word 0 at address 0
38010100 // xori r1, r0, 0x0100
38050200 // xori r5, r0, 0x0200
8C220000 // lw   r2, 0(r1)
8C230004 // lw   r3, 4(r1)
8C240008 // lw   r4, 8(r1)
ACA40000 // sw   r4, 0(r5)
ACA20004 // sw   r2, 4(r5)
00433020 // add  r6, r2, r3
ACA60008 // sw   r6, 8(r5)
00433822 // sub  r7, r2, r3
ACA7000C // sw   r7, 12(r5)
0043402A // slt  r8, r2, r3
ACA80010 // sw   r8, 16(r5)
0062482A // slt  r9, r3, r2
ACA90014 // sw   r9, 20(r5)
388A8001 // xori r10, r4, 0x8001
ACAA0018 // sw   r10, 24(r5)
00830020 // add  r0, r4, r3
ACA0001C // sw   r0, 28(r5)
14430001 // bne  r2, r3, +1 taken
ACA40020 // sw   r4, 32(r5) skipped
14630001 // bne  r3, r3, +1 not taken
ACA30024 // sw   r3, 36(r5)
20630001 // addi r3, r3, 1 unlisted opcode
00001824 // and  r3, r0, r0 unlisted funct
ACA30028 // sw   r3, 40(r5)
0800001C // j    word 28
ACA4002C // sw   r4, 44(r5) skipped
0C00001F // jal  word 31
ACBF0030 // sw   r31, 48(r5) after return
0800001E // j    word 30, final loop
ACA50034 // sw   r5, 52(r5)
03E00008 // jr   r31
// Data memory preload
00000100 FFFFFFF9
00000104 0000000C
00000108 12345678
// Expected stores in order
00000200 12345678
00000204 FFFFFFF9
00000208 00000005
0000020C FFFFFFED
00000210 00000001
00000214 00000000
00000218 1234D679
0000021C 00000000
00000224 0000000C
00000228 0000000C
00000234 00000200
00000230 00000074

//--- files.f
+incdir+include
rtl/cpuPkg.sv
rtl/controlDecoder.sv
rtl/alu.sv
rtl/regFile.sv
rtl/fetchUnit.sv
rtl/cpuCore.sv
bench/tbCpu.sv

//--- Makefile
all: build
	./obj_dir/simCpu | tee /dev/stderr | grep "^Finished with no errors$$" > /dev/null

build:
	verilator --binary --timing --assert -f files.f --top-module tbCpu -o simCpu

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module cpuCore

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
